//--- src/isa_pkg.sv
/*
 * Instruction set of the scalar unit
 * Opcode encoding, 32-bit instruction layout and decode helpers
 */
package isa_pkg;

	////////////////////////////////////////
	// Instruction word geometry
	////////////////////////////////////////
	localparam int INSTR_WIDTH     = 32;
	localparam int OPCODE_WIDTH    = 4;
	localparam int REG_FIELD_WIDTH = 4;
	localparam int IMM_WIDTH       = 16;

	// Opcodes sit in the top nibble of the word
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_SHR  = 4'h7,
		OP_ADDI = 4'h8,
		OP_LDI  = 4'h9,
		OP_STO  = 4'ha,
		OP_BRZ  = 4'hb,
		OP_BRN  = 4'hc,
		OP_JMP  = 4'hd,
		OP_HALT = 4'he
	} opcode_e;

	// Fields from the top bits down
	typedef struct packed {
		opcode_e                    opcode;
		logic [REG_FIELD_WIDTH-1:0] dst;
		logic [REG_FIELD_WIDTH-1:0] src1;
		logic [REG_FIELD_WIDTH-1:0] src2;
		logic [IMM_WIDTH-1:0]       imm;
	} instr_t;

	////////////////////////////////////////
	// Decode helpers
	////////////////////////////////////////
	function automatic logic writes_reg(input opcode_e op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SHL, OP_SHR, OP_ADDI, OP_LDI: begin
				return 1'b1;
			end
			default: begin
				return 1'b0;
			end
		endcase
	endfunction

	// Every register-writing op also updates zero and negative
	function automatic logic sets_flags(input opcode_e op);
		return writes_reg(op);
	endfunction

endpackage

//--- src/scalar_pkg.sv
/*
 * Scalar unit machine sizes and pipeline types
 * Data and index types plus the structs passed between stages
 */
package scalar_pkg;

	localparam int DATA_WIDTH    = 32;
	localparam int NUM_REGS      = 16;
	localparam int PC_WIDTH      = 8;
	localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);
	localparam int SHAMT_WIDTH   = $clog2(DATA_WIDTH);
	localparam int ST_ADDR_WIDTH = 16;

	typedef logic [DATA_WIDTH-1:0]    data_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [PC_WIDTH-1:0]      pc_t;

	typedef struct packed {
		logic zero;
		logic neg;
	} status_t;

	////////////////////////////////////////
	// Control flow back to fetch
	////////////////////////////////////////
	// Strobe with taken set loads the target
	// Strobe alone is a halt
	typedef struct packed {
		logic strobe;
		logic taken;
		pc_t  target;
	} redirect_t;

	////////////////////////////////////////
	// Pipeline payloads
	////////////////////////////////////////
	typedef struct packed {
		logic            valid;
		isa_pkg::instr_t instr;
	} fetch_t;

	// Operand to execute register
	typedef struct packed {
		logic                          valid;
		isa_pkg::opcode_e              op;
		reg_idx_t                      dst;
		data_t                         src1_data;
		data_t                         src2_data;
		logic [isa_pkg::IMM_WIDTH-1:0] imm;
	} exec_cmd_t;

	// Write-back that also feeds forwarding
	typedef struct packed {
		logic     we;
		reg_idx_t idx;
		data_t    data;
	} wb_t;

	typedef struct packed {
		logic                     strobe;
		logic [ST_ADDR_WIDTH-1:0] addr;
		data_t                    data;
	} store_t;

endpackage

//--- src/fetch_unit.sv
/*
 * Fetch unit
 * Holds the run state and program counter, reads the instruction
 * memory once per cycle and follows redirects from execute
 */
`timescale 1ns/100ps

module fetch_unit (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              start,
	input  scalar_pkg::redirect_t             redirect,
	input  logic [isa_pkg::INSTR_WIDTH-1:0]   imem_data,
	output logic                              imem_re,
	output scalar_pkg::pc_t                   imem_addr,
	output scalar_pkg::fetch_t                fetch
);

	import scalar_pkg::*;
	import isa_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} run_state_e;

	run_state_e state;
	pc_t        pc;
	logic       pending;

	////////////////////////////////////////
	// Run state and program counter
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			pc    <= '0;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_RUN;
						pc    <= '0;
					end
				end
				ST_RUN: begin
					if (redirect.strobe && !redirect.taken) begin
						// Halt reached execute
						state <= ST_IDLE;
					end
					else if (redirect.strobe) begin
						pc <= redirect.target;
					end
					else begin
						pc <= pc + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign imem_re   = (state == ST_RUN);
	assign imem_addr = pc;

	// Word requested this cycle returns next cycle
	// A redirect makes the word in flight stale
	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end
		else begin
			pending <= imem_re && !redirect.strobe;
		end
	end

	assign fetch.valid = pending;
	assign fetch.instr = instr_t'(imem_data);

endmodule

//--- src/reg_file.sv
/*
 * Register file
 * 16 x 32 bits, two combinational read ports and one write port
 */
`timescale 1ns/100ps

module reg_file (
	input  logic                 clock,
	input  logic                 reset,
	input  scalar_pkg::reg_idx_t rd_idx_a,
	input  scalar_pkg::reg_idx_t rd_idx_b,
	output scalar_pkg::data_t    rd_data_a,
	output scalar_pkg::data_t    rd_data_b,
	input  scalar_pkg::wb_t      wb
);

	import scalar_pkg::*;

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wb.we) begin
			regs[wb.idx] <= wb.data;
		end
	end

	// A same-cycle write returns the old value
	// Bypass sits in the operand stage
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

//--- src/operand_stage.sv
/*
 * Operand stage
 * Decodes the arriving instruction, reads both sources with
 * forwarding from execute and loads the execute command register
 */
`timescale 1ns/100ps

module operand_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  scalar_pkg::fetch_t    fetch,
	input  scalar_pkg::redirect_t redirect,
	input  scalar_pkg::wb_t       wb,
	output scalar_pkg::reg_idx_t  rd_idx_a,
	output scalar_pkg::reg_idx_t  rd_idx_b,
	input  scalar_pkg::data_t     rd_data_a,
	input  scalar_pkg::data_t     rd_data_b,
	output scalar_pkg::exec_cmd_t cmd
);

	import scalar_pkg::*;
	import isa_pkg::*;

	instr_t    instr;
	logic      flush;
	logic      fwd_a;
	logic      fwd_b;
	exec_cmd_t cmd_next;

	assign instr = fetch.instr;

	// Taken branches and halt both squash the younger instruction
	assign flush = redirect.strobe;

	////////////////////////////////////////
	// Register read with bypass
	////////////////////////////////////////
	assign rd_idx_a = instr.src1;
	assign rd_idx_b = instr.src2;

	// Execute result is not in the register file until cycle end
	assign fwd_a = wb.we && (wb.idx == rd_idx_a);
	assign fwd_b = wb.we && (wb.idx == rd_idx_b);

	always_comb begin
		cmd_next.valid     = fetch.valid && !flush;
		// Empty slot decodes as NOP
		cmd_next.op        = fetch.valid ? instr.opcode : OP_NOP;
		cmd_next.dst       = instr.dst;
		cmd_next.src1_data = fwd_a ? wb.data : rd_data_a;
		cmd_next.src2_data = fwd_b ? wb.data : rd_data_b;
		cmd_next.imm       = instr.imm;
	end

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd.valid <= 1'b0;
			cmd.op    <= OP_NOP;
		end
		else begin
			cmd <= cmd_next;
		end
	end

endmodule

//--- src/exec_unit.sv
/*
 * Execute and write-back
 * ALU, status flags, branch resolution, register write-back,
 * store request and halt
 */
`timescale 1ns/100ps

module exec_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  scalar_pkg::exec_cmd_t cmd,
	output scalar_pkg::wb_t       wb,
	output scalar_pkg::redirect_t redirect,
	output scalar_pkg::store_t    store,
	output scalar_pkg::status_t   status,
	output logic                  term
);

	import scalar_pkg::*;
	import isa_pkg::*;

	data_t                  imm_sext;
	logic [SHAMT_WIDTH-1:0] shamt;
	data_t                  result;
	logic                   alu_en;
	logic                   flag_en;
	logic                   br_taken;
	logic                   is_halt;

	assign imm_sext = {{(DATA_WIDTH-IMM_WIDTH){cmd.imm[IMM_WIDTH-1]}}, cmd.imm};
	assign shamt    = cmd.src2_data[SHAMT_WIDTH-1:0];

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (cmd.op)
			OP_ADD:  result = cmd.src1_data + cmd.src2_data;
			OP_SUB:  result = cmd.src1_data - cmd.src2_data;
			OP_AND:  result = cmd.src1_data & cmd.src2_data;
			OP_OR:   result = cmd.src1_data | cmd.src2_data;
			OP_XOR:  result = cmd.src1_data ^ cmd.src2_data;
			OP_SHL:  result = cmd.src1_data << shamt;
			OP_SHR:  result = cmd.src1_data >> shamt;
			OP_ADDI: result = cmd.src1_data + imm_sext;
			OP_LDI:  result = imm_sext;
			default: result = '0;
		endcase
	end

	assign alu_en  = cmd.valid && writes_reg(cmd.op);
	assign flag_en = cmd.valid && sets_flags(cmd.op);

	// Same cycle as the ALU so operand stage can forward
	always_comb begin
		wb.we   = alu_en;
		wb.idx  = cmd.dst;
		wb.data = result;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end
		else if (flag_en) begin
			status.zero <= (result == '0);
			status.neg  <= result[DATA_WIDTH-1];
		end
	end

	////////////////////////////////////////
	// Control flow
	////////////////////////////////////////
	// Branches test the flags left by the last ALU op
	always_comb begin
		case (cmd.op)
			OP_BRZ:  br_taken = status.zero;
			OP_BRN:  br_taken = status.neg;
			OP_JMP:  br_taken = 1'b1;
			default: br_taken = 1'b0;
		endcase
	end

	assign is_halt = cmd.valid && (cmd.op == OP_HALT);

	always_comb begin
		redirect.taken  = cmd.valid && br_taken;
		redirect.strobe = redirect.taken || is_halt;
		redirect.target = cmd.imm[PC_WIDTH-1:0];
	end

	// Store and term leave one cycle after execute
	always_ff @(posedge clock) begin
		if (reset) begin
			store.strobe <= 1'b0;
			term         <= 1'b0;
		end
		else begin
			store.strobe <= cmd.valid && (cmd.op == OP_STO);
			store.addr   <= cmd.imm;
			store.data   <= cmd.src1_data;
			term         <= is_halt;
		end
	end

endmodule

//--- src/scalar_unit.sv
/*
 * Scalar unit top level
 * Three-stage pipeline of fetch, operand and execute around
 * the register file
 */
`timescale 1ns/100ps

module scalar_unit (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	output logic                            imem_re,
	output scalar_pkg::pc_t                 imem_addr,
	input  logic [isa_pkg::INSTR_WIDTH-1:0] imem_data,
	output scalar_pkg::store_t              store,
	output scalar_pkg::status_t             status,
	output logic                            term
);

	import scalar_pkg::*;

	fetch_t    fetch;
	exec_cmd_t cmd;
	wb_t       wb;
	redirect_t redirect;
	reg_idx_t  rd_idx_a;
	reg_idx_t  rd_idx_b;
	data_t     rd_data_a;
	data_t     rd_data_b;

	fetch_unit u_fetch (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.redirect  (redirect),
		.imem_data (imem_data),
		.imem_re   (imem_re),
		.imem_addr (imem_addr),
		.fetch     (fetch)
	);

	operand_stage u_operand (
		.clock     (clock),
		.reset     (reset),
		.fetch     (fetch),
		.redirect  (redirect),
		.wb        (wb),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.cmd       (cmd)
	);

	reg_file u_reg_file (
		.clock     (clock),
		.reset     (reset),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb        (wb)
	);

	exec_unit u_exec (
		.clock    (clock),
		.reset    (reset),
		.cmd      (cmd),
		.wb       (wb),
		.redirect (redirect),
		.store    (store),
		.status   (status),
		.term     (term)
	);

endmodule

//--- test/instr_mem_model.sv
/*
 * Instruction memory model
 * 256 words, one-cycle read latency, write port for program loading
 */
`timescale 1ns/100ps

module instr_mem_model (
	input  logic                            clock,
	input  logic                            re,
	input  scalar_pkg::pc_t                 addr,
	output logic [isa_pkg::INSTR_WIDTH-1:0] data,
	input  logic                            we,
	input  scalar_pkg::pc_t                 waddr,
	input  logic [isa_pkg::INSTR_WIDTH-1:0] wdata
);

	import scalar_pkg::*;
	import isa_pkg::*;

	logic [INSTR_WIDTH-1:0] mem [2**PC_WIDTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		// Word appears one cycle after the request
		if (re) begin
			data <= mem[addr];
		end
	end

endmodule

//--- test/tb_scalar_unit.sv
/*
 * Testbench for the scalar unit
 * Builds random programs, predicts stores and flags with an
 * instruction-level model and checks the DUT against it
 */
`timescale 1ns/100ps

module tb_scalar_unit;

	import scalar_pkg::*;
	import isa_pkg::*;

	localparam logic [31:0] RANDOM_SEED = 32'ha2b1015e;
	localparam int          RUN_TIMEOUT = 500;
	localparam int          STEP_LIMIT  = 1000;
	localparam int          MEM_WORDS   = 2**PC_WIDTH;

	logic                   clock;
	logic                   reset;
	logic                   start;
	logic                   imem_re;
	pc_t                    imem_addr;
	logic [INSTR_WIDTH-1:0] imem_data;
	store_t                 store;
	status_t                status;
	logic                   term;
	logic                   mem_we;
	pc_t                    mem_waddr;
	logic [INSTR_WIDTH-1:0] mem_wdata;

	logic [INSTR_WIDTH-1:0] prog [MEM_WORDS];
	int                     prog_len;
	store_t                 exp_stores [$];
	store_t                 next_store;
	int                     term_count;
	int                     value_errors;
	int                     other_errors;

	scalar_unit uut (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.imem_re   (imem_re),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.store     (store),
		.status    (status),
		.term      (term)
	);

	instr_mem_model imem (
		.clock (clock),
		.re    (imem_re),
		.addr  (imem_addr),
		.data  (imem_data),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic status_t interpret_program(output logic halted);
		data_t   regs [NUM_REGS];
		status_t flags;
		instr_t  ins;
		data_t   a;
		data_t   b;
		data_t   imm_sext;
		data_t   res;
		logic    write;
		store_t  st;
		int      pc;
		int      steps;

		exp_stores.delete();
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
		flags  = '0;
		halted = 1'b0;
		pc     = 0;
		steps  = 0;
		while (!halted && steps < STEP_LIMIT) begin
			ins      = instr_t'(prog[pc]);
			a        = regs[ins.src1];
			b        = regs[ins.src2];
			imm_sext = {{16{ins.imm[15]}}, ins.imm};
			pc       = (pc + 1) % MEM_WORDS;
			res      = '0;
			write    = 1'b1;
			case (ins.opcode)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SHL:  res = a << b[4:0];
				OP_SHR:  res = a >> b[4:0];
				OP_ADDI: res = a + imm_sext;
				OP_LDI:  res = imm_sext;
				default: write = 1'b0;
			endcase
			if (write) begin
				regs[ins.dst] = res;
				flags.zero    = (res == '0);
				flags.neg     = res[31];
			end
			case (ins.opcode)
				OP_STO: begin
					st.strobe = 1'b1;
					st.addr   = ins.imm;
					st.data   = a;
					exp_stores.push_back(st);
				end
				OP_BRZ:  if (flags.zero) pc = ins.imm[7:0];
				OP_BRN:  if (flags.neg) pc = ins.imm[7:0];
				OP_JMP:  pc = ins.imm[7:0];
				OP_HALT: halted = 1'b1;
				default: ;
			endcase
			steps++;
		end
		return flags;
	endfunction

	////////////////////////////////////////
	// Program building
	////////////////////////////////////////
	// Unused words hold a HALT carrying their own address
	function automatic logic [INSTR_WIDTH-1:0] fill_word(input int addr);
		instr_t w;

		w        = '0;
		w.opcode = OP_HALT;
		w.imm    = 16'(addr);
		return w;
	endfunction

	task automatic clear_program();
		for (int a = 0; a < MEM_WORDS; a++) begin
			prog[a] = fill_word(a);
		end
		prog_len = 0;
	endtask

	task automatic emit(input opcode_e op, input int dst, input int s1, input int s2,
			input int imm);
		instr_t w;

		w.opcode       = op;
		w.dst          = 4'(dst);
		w.src1         = 4'(s1);
		w.src2         = 4'(s2);
		w.imm          = 16'(imm);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Zero, positive or negative immediate
	function automatic logic [15:0] pick_value(input int kind);
		case (kind)
			0:       return 16'h0000;
			1:       return 16'($urandom_range(1, 16'h7fff));
			default: return 16'h8000 | 16'($urandom_range(0, 16'h7fff));
		endcase
	endfunction

	// Each op reads the result just before it, on src1 and src2 in turn
	task automatic build_alu_program();
		clear_program();
		// r0 still holds its reset value here
		emit(OP_STO,  0, 0, 0, 'h0ff);
		emit(OP_LDI,  1, 0, 0, $urandom());
		emit(OP_LDI,  2, 0, 0, $urandom());
		emit(OP_ADD,  3, 1, 2, 0);
		emit(OP_SUB,  4, 3, 1, 0);
		emit(OP_AND,  5, 2, 4, 0);
		emit(OP_OR,   6, 5, 3, 0);
		emit(OP_XOR,  7, 1, 6, 0);
		emit(OP_SHL,  8, 7, 2, 0);
		emit(OP_SHR,  9, 1, 8, 0);
		emit(OP_ADDI, 0, 9, 0, $urandom());
		emit(OP_STO,  0, 0, 0, 'h107);
		emit(OP_STO,  0, 3, 0, 'h100);
		emit(OP_STO,  0, 4, 0, 'h101);
		emit(OP_STO,  0, 5, 0, 'h102);
		emit(OP_STO,  0, 6, 0, 'h103);
		emit(OP_STO,  0, 7, 0, 'h104);
		emit(OP_STO,  0, 8, 0, 'h105);
		emit(OP_STO,  0, 9, 0, 'h106);
		emit(OP_HALT, 0, 0, 0, 0);
		// Squashed by the halt
		emit(OP_STO,  0, 1, 0, 'h1ff);
	endtask

	task automatic build_branch_program(input int kind_z, input int kind_n);
		clear_program();
		emit(OP_LDI,  1, 0, 0, pick_value(kind_z));
		emit(OP_BRZ,  0, 0, 0, 4);
		emit(OP_STO,  0, 1, 0, 'h11);
		emit(OP_STO,  0, 1, 0, 'h12);
		emit(OP_LDI,  2, 0, 0, pick_value(kind_n));
		emit(OP_BRN,  0, 0, 0, 8);
		emit(OP_STO,  0, 2, 0, 'h21);
		emit(OP_STO,  0, 2, 0, 'h22);
		emit(OP_SUB,  3, 1, 1, 0);
		emit(OP_BRN,  0, 0, 0, 11);
		emit(OP_STO,  0, 3, 0, 'h31);
		emit(OP_HALT, 0, 0, 0, 0);
	endtask

	// Counter loop closed by a backward JMP
	task automatic build_loop_program();
		clear_program();
		emit(OP_LDI,  1, 0, 0, $urandom_range(2, 6));
		emit(OP_LDI,  2, 0, 0, 0);
		emit(OP_JMP,  0, 0, 0, 5);
		emit(OP_STO,  0, 1, 0, 'hdead);
		emit(OP_STO,  0, 2, 0, 'hbeef);
		emit(OP_ADDI, 2, 2, 0, 3);
		emit(OP_STO,  0, 2, 0, 'h40);
		emit(OP_ADDI, 1, 1, 0, -1);
		emit(OP_BRZ,  0, 0, 0, 10);
		emit(OP_JMP,  0, 0, 0, 5);
		emit(OP_STO,  0, 1, 0, 'h50);
		emit(OP_HALT, 0, 0, 0, 0);
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////
	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		start <= 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value("imem_re", imem_re, 1'b0);
		check_value("store.strobe", store.strobe, 1'b0);
		check_value("term", term, 1'b0);
		check_value("status", status, 2'b00);
	endtask

	task automatic load_program();
		for (int a = 0; a < MEM_WORDS; a++) begin
			@(posedge clock);
			mem_we    <= 1'b1;
			mem_waddr <= pc_t'(a);
			mem_wdata <= prog[a];
		end
		@(posedge clock);
		mem_we <= 1'b0;
	endtask

	task automatic run_program(input string name);
		status_t exp_status;
		logic    exp_halt;
		int      cycles;

		apply_reset();
		load_program();
		exp_status = interpret_program(exp_halt);
		if (!exp_halt) begin
			$display("Reference model for the %s program never reached HALT", name);
			other_errors++;
		end
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		// First fetch goes to address 0 in the cycle after start
		@(posedge clock);
		check_value("imem_re", imem_re, 1'b1);
		check_value("imem_addr", imem_addr, 8'h00);
		cycles = 0;
		while (term_count == 0 && cycles < RUN_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (term_count == 0) begin
			$display("Timeout: %s program gave no term within %0d cycles", name, RUN_TIMEOUT);
			other_errors++;
		end
		// Fetch must stay quiet after the halt
		repeat (5) begin
			@(posedge clock);
			check_value("imem_re", imem_re, 1'b0);
		end
		if (exp_stores.size() != 0) begin
			$display("The %s program left %0d expected stores unseen", name, exp_stores.size());
			other_errors++;
		end
		check_value("status", status, exp_status);
		check_value("term pulses", term_count, 1);
	endtask

	// Stores are checked in program order
	always @(posedge clock) begin
		if (reset) begin
			term_count <= 0;
		end
		else begin
			if (store.strobe) begin
				if (exp_stores.size() == 0) begin
					$display("Unexpected store to address 0x%0h at %0t", store.addr, $time);
					other_errors++;
				end
				else begin
					next_store = exp_stores.pop_front();
					check_value("store.addr", store.addr, next_store.addr);
					check_value("store.data", store.data, next_store.data);
				end
			end
			if (term) begin
				term_count <= term_count + 1;
			end
		end
	end

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		start        = 1'b0;
		mem_we       = 1'b0;
		mem_waddr    = '0;
		mem_wdata    = '0;
		value_errors = 0;
		other_errors = 0;
		void'($urandom(RANDOM_SEED));

		for (int i = 0; i < 2; i++) begin
			build_alu_program();
			run_program("ALU");
		end
		// Every zero, positive, negative pair for BRZ and BRN
		for (int k = 0; k < 9; k++) begin
			build_branch_program(k % 3, k / 3);
			run_program("branch");
		end
		for (int i = 0; i < 2; i++) begin
			build_loop_program();
			run_program("loop");
		end

		$display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Regression passed");
		end
		else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
src/isa_pkg.sv
src/scalar_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/operand_stage.sv
src/exec_unit.sv
src/scalar_unit.sv
test/instr_mem_model.sv
test/tb_scalar_unit.sv

//--- Bender.yml
package:
  name: scalar_unit

sources:
  - src/isa_pkg.sv
  - src/scalar_pkg.sv
  - src/fetch_unit.sv
  - src/reg_file.sv
  - src/operand_stage.sv
  - src/exec_unit.sv
  - src/scalar_unit.sv
  - target: test
    files:
      - test/instr_mem_model.sv
      - test/tb_scalar_unit.sv
